/* hw/buf_cfg_pkg.sv */
package buf_cfg_pkg;

  // Entry count and the widths that follow from it.
  localparam int buf_depth = 32;
  localparam int addr_width = 5;

  // One extra bit so a full queue of 32 can be counted.
  localparam int count_width = 6;

  // Bank numbering within one interleaved word.
  localparam logic queue_bank = 1'b1;
  localparam logic side_bank = 1'b0;

endpackage

/* hw/bus_msg_pkg.sv */
package bus_msg_pkg;

  // Payload is carried as 16 lanes of 32 bits.
  localparam int lane_width = 32;
  localparam int lane_count = 16;
  localparam int payload_width = lane_width * lane_count;

  // Header fields.
  localparam int sig_width = 24;
  localparam int req_width = 10;

  // Header layout, MSB first: signals, source tag, destination tag.
  localparam int hdr_width = sig_width + 2 * req_width;

endpackage

/* hw/msg_bank_store.sv */
`timescale 1ns/100ps

module msg_bank_store
  import bus_msg_pkg::*, buf_cfg_pkg::*;
(
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     wen,
  input  logic [addr_width-1:0]    waddr,
  input  logic                     wbank,
  input  logic [payload_width-1:0] wdata,
  input  logic [sig_width-1:0]     wsig,
  input  logic [req_width-1:0]     wsrc,
  input  logic [req_width-1:0]     wdst,
  input  logic                     ren,
  input  logic                     rbank,
  input  logic [addr_width-1:0]    rd_ptr,
  output logic [payload_width-1:0] rdata,
  output logic [sig_width-1:0]     rsig,
  output logic [req_width-1:0]     rsrc,
  output logic [req_width-1:0]     rdst
);

  logic [2*payload_width-1:0] wdata_il;
  logic [2*payload_width-1:0] rdata_il;
  logic [2*lane_width-1:0]    lane_ben;
  logic [hdr_width-1:0]       whdr;
  logic [hdr_width-1:0]       rhdr;
  logic [2*hdr_width-1:0]     whdr_il;
  logic [2*hdr_width-1:0]     rhdr_il;
  logic [2*hdr_width-1:0]     hdr_ben;
  logic                       rbank_q;

  // Bank 1 sits on odd bits, bank 0 on even bits.
  assign lane_ben = {lane_width{{wbank, ~wbank}}};
  assign hdr_ben  = {hdr_width{{wbank, ~wbank}}};

  assign whdr = {wsig, wsrc, wdst};

  always_ff @(posedge clk) begin
    if (rst) begin
      rbank_q <= side_bank;
    end else if (ren) begin
      rbank_q <= rbank;
    end
  end

  // Spread writes into both positions, pick one on reads.
  always_comb begin
    for (int k = 0; k < payload_width; k++) begin
      wdata_il[2*k +: 2] = {2{wdata[k]}};
      rdata[k] = rbank_q ? rdata_il[2*k+1] : rdata_il[2*k];
    end
    for (int k = 0; k < hdr_width; k++) begin
      whdr_il[2*k +: 2] = {2{whdr[k]}};
      rhdr[k] = rbank_q ? rhdr_il[2*k+1] : rhdr_il[2*k];
    end
  end

  assign {rsig, rsrc, rdst} = rhdr;

  for (genvar l = 0; l < lane_count; l++) begin : g_lane
    msg_lane_ram #(
      .ram_width(lane_width)
    ) ram_i (
      .clk  (clk),
      .wen  (wen),
      .waddr(waddr),
      .wdata(wdata_il[2*lane_width*l +: 2*lane_width]),
      .wben (lane_ben),
      .ren  (ren),
      .raddr(rd_ptr),
      .rdata(rdata_il[2*lane_width*l +: 2*lane_width])
    );
  end

  // Header shares the lane RAM, just wider.
  msg_lane_ram #(
    .ram_width(hdr_width)
  ) hdr_ram_i (
    .clk  (clk),
    .wen  (wen),
    .waddr(waddr),
    .wdata(whdr_il),
    .wben (hdr_ben),
    .ren  (ren),
    .raddr(rd_ptr),
    .rdata(rhdr_il)
  );

endmodule

/* hw/msg_buffer_top.sv */
`timescale 1ns/100ps

module msg_buffer_top
  import bus_msg_pkg::*, buf_cfg_pkg::*;
#(
  parameter int stall_level = 24,
  parameter int hold_cycles = 15
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     wen,
  input  logic [addr_width-1:0]    waddr,
  input  logic                     wbank,
  input  logic [payload_width-1:0] wdata,
  input  logic [sig_width-1:0]     wsig,
  input  logic [req_width-1:0]     wsrc,
  input  logic [req_width-1:0]     wdst,
  input  logic                     ren,
  input  logic                     rbank,
  output logic [payload_width-1:0] rdata,
  output logic [sig_width-1:0]     rsig,
  output logic [req_width-1:0]     rsrc,
  output logic [req_width-1:0]     rdst,
  output logic                     stall
);

  logic [addr_width-1:0] rd_ptr;

  msg_queue_ctrl #(
    .stall_level(stall_level),
    .hold_cycles(hold_cycles)
  ) ctrl_i (
    .clk   (clk),
    .rst   (rst),
    .wen   (wen),
    .wbank (wbank),
    .ren   (ren),
    .rbank (rbank),
    .rd_ptr(rd_ptr),
    .stall (stall)
  );

  // Reads always come from the queue pointer.
  msg_bank_store store_i (
    .clk   (clk),
    .rst   (rst),
    .wen   (wen),
    .waddr (waddr),
    .wbank (wbank),
    .wdata (wdata),
    .wsig  (wsig),
    .wsrc  (wsrc),
    .wdst  (wdst),
    .ren   (ren),
    .rbank (rbank),
    .rd_ptr(rd_ptr),
    .rdata (rdata),
    .rsig  (rsig),
    .rsrc  (rsrc),
    .rdst  (rdst)
  );

endmodule

/* hw/msg_lane_ram.sv */
`timescale 1ns/100ps

module msg_lane_ram
  import buf_cfg_pkg::*;
#(
  parameter int ram_width = 32
) (
  input  logic                   clk,
  input  logic                   wen,
  input  logic [addr_width-1:0]  waddr,
  input  logic [2*ram_width-1:0] wdata,
  input  logic [2*ram_width-1:0] wben,
  input  logic                   ren,
  input  logic [addr_width-1:0]  raddr,
  output logic [2*ram_width-1:0] rdata
);

  logic [2*ram_width-1:0] mem [buf_depth];
  logic [addr_width-1:0]  raddr_q;

  always_ff @(posedge clk) begin
    if (ren) begin
      raddr_q <= raddr;
    end
    // Bit-level enables keep the other bank of the word intact.
    if (wen) begin
      for (int b = 0; b < 2 * ram_width; b++) begin
        if (wben[b]) begin
          mem[waddr][b] <= wdata[b];
        end
      end
    end
  end

  // Read port follows the registered address.
  assign rdata = mem[raddr_q];

endmodule

/* hw/msg_queue_ctrl.sv */
`timescale 1ns/100ps

module msg_queue_ctrl
  import buf_cfg_pkg::*;
#(
  parameter int stall_level = 24,
  parameter int hold_cycles = 15
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  wen,
  input  logic                  wbank,
  input  logic                  ren,
  input  logic                  rbank,
  output logic [addr_width-1:0] rd_ptr,
  output logic                  stall
);

  localparam int hold_width = $clog2(hold_cycles + 1);

  logic [count_width-1:0] count_q;
  logic [hold_width-1:0]  hold_q;
  logic                   push;
  logic                   pop;
  logic                   side_wr;
  logic                   over_level;

  assign push    = wen && (wbank == queue_bank);
  assign side_wr = wen && (wbank == side_bank);

  // Empty queue reads leave the pointer alone.
  assign pop = ren && (rbank == queue_bank) && (count_q != '0);

  // Queue occupancy.
  always_ff @(posedge clk) begin
    if (rst) begin
      count_q <= '0;
    end else if (push && !pop) begin
      count_q <= count_q + 1'b1;
    end else if (pop && !push) begin
      count_q <= count_q - 1'b1;
    end
  end

  // Read pointer wraps at the end of the RAM.
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_ptr <= '0;
    end else if (pop) begin
      rd_ptr <= rd_ptr + 1'b1;
    end
  end

  // Hold period after each side-store write.
  always_ff @(posedge clk) begin
    if (rst) begin
      hold_q <= '0;
    end else if (side_wr) begin
      hold_q <= hold_width'(hold_cycles);
    end else if (hold_q != '0) begin
      hold_q <= hold_q - 1'b1;
    end
  end

  assign over_level = (count_q >= count_width'(stall_level));

  assign stall = over_level || (hold_q != '0);

endmodule

/* run.sh */
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module msg_buffer_tb -o msg_buffer_sim

./obj_dir/msg_buffer_sim | tee sim.log

if grep -q "Checks failed" sim.log; then
  echo "Simulation reported failures, see sim.log"
  exit 1
fi

if ! grep -q "All checks passed" sim.log; then
  echo "Simulation ended without a result, see sim.log"
  exit 1
fi

echo "Simulation passed"

/* tb.f */
+incdir+verif
hw/bus_msg_pkg.sv
hw/buf_cfg_pkg.sv
hw/msg_lane_ram.sv
hw/msg_bank_store.sv
hw/msg_queue_ctrl.sv
hw/msg_buffer_top.sv
verif/msg_buffer_tb.sv

/* verif/lfsr_util.svh */
`ifndef lfsr_util_svh
`define lfsr_util_svh

// One step of a 32-bit Galois LFSR.
function automatic logic [31:0] lfsr_step(input logic [31:0] state);
  logic [31:0] next;
  next = state >> 1;
  if (state[0]) begin
    next = next ^ 32'h80200003;
  end
  return next;
endfunction

// Takes nbits from the LFSR, one step per bit, LSB first.
task automatic rand_bits(
  inout  logic [31:0]              state,
  input  int                       nbits,
  output logic [payload_width-1:0] value
);
  value = '0;
  for (int i = 0; i < nbits; i++) begin
    value[i] = state[0];
    state = lfsr_step(state);
  end
endtask

`endif

/* verif/msg_buffer_tb.sv */
`timescale 1ns/100ps

module msg_buffer_tb
  import bus_msg_pkg::*, buf_cfg_pkg::*;
;

  localparam int stall_level = 24;
  localparam int hold_cycles = 15;
  localparam int max_cycles = 2000;

  logic                     clk;
  logic                     rst;
  logic                     wen;
  logic [addr_width-1:0]    waddr;
  logic                     wbank;
  logic [payload_width-1:0] wdata;
  logic [sig_width-1:0]     wsig;
  logic [req_width-1:0]     wsrc;
  logic [req_width-1:0]     wdst;
  logic                     ren;
  logic                     rbank;
  logic [payload_width-1:0] rdata;
  logic [sig_width-1:0]     rsig;
  logic [req_width-1:0]     rsrc;
  logic [req_width-1:0]     rdst;
  logic                     stall;

  // Reference model state.
  logic [payload_width-1:0] m_pay [2][buf_depth];
  logic [sig_width-1:0]     m_sig [2][buf_depth];
  logic [req_width-1:0]     m_src [2][buf_depth];
  logic [req_width-1:0]     m_dst [2][buf_depth];
  logic                     m_written [2][buf_depth];
  logic [addr_width-1:0]    m_ptr;
  logic [addr_width-1:0]    m_raddr;
  logic                     m_bank;
  logic                     m_rd_valid;
  int                       m_count;
  int                       m_hold;
  logic                     m_push;
  logic                     m_pop;

  logic [payload_width-1:0] exp_rdata;
  logic [sig_width-1:0]     exp_rsig;
  logic [req_width-1:0]     exp_rsrc;
  logic [req_width-1:0]     exp_rdst;
  logic                     exp_stall;
  logic                     exp_known;

  logic [31:0]              lfsr_state;
  logic [addr_width-1:0]    wr_addr;
  int                       cycle_count;
  int                       held;

  `include "lfsr_util.svh"

  msg_buffer_top #(
    .stall_level(stall_level),
    .hold_cycles(hold_cycles)
  ) dut_i (
    .clk  (clk),
    .rst  (rst),
    .wen  (wen),
    .waddr(waddr),
    .wbank(wbank),
    .wdata(wdata),
    .wsig (wsig),
    .wsrc (wsrc),
    .wdst (wdst),
    .ren  (ren),
    .rbank(rbank),
    .rdata(rdata),
    .rsig (rsig),
    .rsrc (rsrc),
    .rdst (rdst),
    .stall(stall)
  );

  always #10 clk = ~clk;

  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("Checks failed");
    $fatal(1);
  endtask

  assign m_push = wen && (wbank == queue_bank);
  assign m_pop  = ren && (rbank == queue_bank) && (m_count > 0);

  always @(posedge clk) begin
    if (rst) begin
      m_count    <= 0;
      m_ptr      <= '0;
      m_hold     <= 0;
      m_bank     <= side_bank;
      m_rd_valid <= 1'b0;
      for (int e = 0; e < buf_depth; e++) begin
        m_written[0][e] <= 1'b0;
        m_written[1][e] <= 1'b0;
      end
    end else begin
      if (ren) begin
        m_raddr    <= m_ptr;
        m_bank     <= rbank;
        m_rd_valid <= 1'b1;
      end
      if (m_pop) begin
        m_ptr <= m_ptr + 1'b1;
      end
      if (m_push && !m_pop) begin
        m_count <= m_count + 1;
      end else if (m_pop && !m_push) begin
        m_count <= m_count - 1;
      end
      if (wen && (wbank == side_bank)) begin
        m_hold <= hold_cycles;
      end else if (m_hold > 0) begin
        m_hold <= m_hold - 1;
      end
      if (wen) begin
        m_pay[wbank][waddr]     <= wdata;
        m_sig[wbank][waddr]     <= wsig;
        m_src[wbank][waddr]     <= wsrc;
        m_dst[wbank][waddr]     <= wdst;
        m_written[wbank][waddr] <= 1'b1;
      end
    end
  end

  assign exp_rdata = m_pay[m_bank][m_raddr];
  assign exp_rsig  = m_sig[m_bank][m_raddr];
  assign exp_rsrc  = m_src[m_bank][m_raddr];
  assign exp_rdst  = m_dst[m_bank][m_raddr];
  assign exp_known = m_rd_valid && m_written[m_bank][m_raddr];
  assign exp_stall = (m_count >= stall_level) || (m_hold != 0);

  stall_matches: assert property (@(posedge clk) disable iff (rst) stall == exp_stall)
    else stop_on_error($sformatf("error: stall is %0h, expected %0h",
                                 $sampled(stall), $sampled(exp_stall)));
  rdata_matches: assert property (@(posedge clk) disable iff (rst)
                                  exp_known |-> rdata == exp_rdata)
    else stop_on_error($sformatf("error: rdata is %0h, expected %0h",
                                 $sampled(rdata), $sampled(exp_rdata)));
  rsig_matches: assert property (@(posedge clk) disable iff (rst)
                                 exp_known |-> rsig == exp_rsig)
    else stop_on_error($sformatf("error: rsig is %0h, expected %0h",
                                 $sampled(rsig), $sampled(exp_rsig)));
  rsrc_matches: assert property (@(posedge clk) disable iff (rst)
                                 exp_known |-> rsrc == exp_rsrc)
    else stop_on_error($sformatf("error: rsrc is %0h, expected %0h",
                                 $sampled(rsrc), $sampled(exp_rsrc)));
  rdst_matches: assert property (@(posedge clk) disable iff (rst)
                                 exp_known |-> rdst == exp_rdst)
    else stop_on_error($sformatf("error: rdst is %0h, expected %0h",
                                 $sampled(rdst), $sampled(exp_rdst)));

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= max_cycles) begin
      stop_on_error($sformatf("Simulation timed out after %0d cycles", cycle_count));
    end
  end

  // One bus cycle, applied on the falling edge.
  task automatic drive_cycle(
    input logic                  do_wr,
    input logic [addr_width-1:0] addr,
    input logic                  bank,
    input logic                  do_rd,
    input logic                  rd_bank
  );
    logic [payload_width-1:0] word;
    @(negedge clk);
    wen   = do_wr;
    waddr = addr;
    wbank = bank;
    ren   = do_rd;
    rbank = rd_bank;
    if (do_wr) begin
      rand_bits(lfsr_state, payload_width, word);
      wdata = word;
      rand_bits(lfsr_state, sig_width, word);
      wsig = word[sig_width-1:0];
      rand_bits(lfsr_state, req_width, word);
      wsrc = word[req_width-1:0];
      rand_bits(lfsr_state, req_width, word);
      wdst = word[req_width-1:0];
    end
  endtask

  task automatic idle(input int n);
    repeat (n) drive_cycle(1'b0, '0, 1'b0, 1'b0, 1'b0);
  endtask

  task automatic push_msg();
    drive_cycle(1'b1, wr_addr, queue_bank, 1'b0, 1'b0);
    wr_addr = wr_addr + 1'b1;
  endtask

  task automatic pop_msg();
    drive_cycle(1'b0, '0, 1'b0, 1'b1, queue_bank);
  endtask

  task automatic push_pop();
    drive_cycle(1'b1, wr_addr, queue_bank, 1'b1, queue_bank);
    wr_addr = wr_addr + 1'b1;
  endtask

  task automatic side_write(input logic [addr_width-1:0] addr);
    drive_cycle(1'b1, addr, side_bank, 1'b0, 1'b0);
  endtask

  task automatic side_read();
    drive_cycle(1'b0, '0, 1'b0, 1'b1, side_bank);
  endtask

  task automatic random_gap();
    logic [payload_width-1:0] word;
    rand_bits(lfsr_state, 1, word);
    if (word[0]) begin
      idle(1);
    end
  endtask

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    wen = 1'b0;
    waddr = '0;
    wbank = 1'b0;
    wdata = '0;
    wsig = '0;
    wsrc = '0;
    wdst = '0;
    ren = 1'b0;
    rbank = 1'b0;
    lfsr_state = 32'h4678574d;
    wr_addr = '0;
    cycle_count = 0;
    held = 0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    // Empty pop, then the first message must still come from entry 0.
    pop_msg();
    idle(1);
    push_msg();
    idle(1);
    pop_msg();
    idle(2);

    // Fill to the stall level, drop below it, then push and pop together.
    repeat (24) push_msg();
    idle(2);
    pop_msg();
    idle(2);
    repeat (4) push_pop();
    idle(1);
    push_msg();
    idle(2);
    repeat (12) begin
      pop_msg();
      random_gap();
    end

    // Writes wrap past entry 31.
    repeat (10) push_msg();
    idle(1);

    // Side store write at the pointer and the length of its hold period.
    side_write(m_ptr);
    repeat (hold_cycles + 3) begin
      idle(1);
      if (stall) begin
        held++;
      end
    end
    held_matches: assert (held == hold_cycles)
      else stop_on_error($sformatf("error: stall high cycles is %0h, expected %0h",
                                   held, hold_cycles));
    side_read();
    idle(1);
    pop_msg();
    idle(1);
    side_write(m_ptr + 5'd6);
    idle(2);

    // Drain, so reads wrap as well.
    repeat (21) begin
      pop_msg();
      random_gap();
    end
    pop_msg();
    idle(3);

    $display("All checks passed");
    $finish;
  end

endmodule
